/* vec_unit_cfg.svh */
//////////////////////////////////////////////////
// Build-time sizes of the vector unit
//////////////////////////////////////////////////

`ifndef VEC_UNIT_CFG_SVH
`define VEC_UNIT_CFG_SVH

//////////////////////////////////////////////////
// Lane array

// Number of lanes, power of two from 1 to 8
`define VEC_NR_LANES 4

//////////////////////////////////////////////////
// Register file geometry

// Element width in bits
`define VEC_ELEN 32

// Elements of each register held by one lane
`define VEC_ELEMS_PER_LANE 4

// Architectural vector registers, 3-bit index
`define VEC_NR_VREGS 8

`endif

/* vec_isa_pkg.sv */
//////////////////////////////////////////////////
// Instruction word encodings and opcodes
//////////////////////////////////////////////////

`default_nettype none

`include "vec_unit_cfg.svh"

package vec_isa_pkg;

  localparam int unsigned INSN_W    = 64;
  localparam int unsigned REG_IDX_W = $clog2(`VEC_NR_VREGS);

  typedef logic [REG_IDX_W-1:0] vreg_idx_t;
  typedef logic [`VEC_ELEN-1:0] elem_t;

  // Opcode field, top nibble of every instruction
  typedef enum logic [3:0] {
    OP_VADD    = 4'h0,
    OP_VAND    = 4'h1,
    OP_VSPLAT  = 4'h2,
    OP_VMV_XS  = 4'h3,
    OP_VREDSUM = 4'h4
  } vec_op_e;

  //////////////////////////////////////////////////
  // Two views of the same 64-bit word

  // Register-register form
  typedef struct packed {
    vec_op_e                        opcode;
    vreg_idx_t                      vd;
    vreg_idx_t                      vs1;
    vreg_idx_t                      vs2;
    logic [INSN_W-4-3*REG_IDX_W-1:0] pad;
  } insn_vv_t;

  // Scalar operand form, scalar in the low word
  typedef struct packed {
    vec_op_e                                opcode;
    vreg_idx_t                              vd;
    logic [INSN_W-4-REG_IDX_W-`VEC_ELEN-1:0] pad;
    elem_t                                  scalar;
  } insn_vx_t;

  typedef union packed {
    insn_vv_t vv;
    insn_vx_t vx;
  } vec_insn_u;

endpackage : vec_isa_pkg

`default_nettype wire

/* vec_lane_pkg.sv */
//////////////////////////////////////////////////
// Sequencer to lane request, lane result
//////////////////////////////////////////////////

`default_nettype none

package vec_lane_pkg;

  // Broadcast to every lane for one instruction
  typedef struct packed {
    vec_isa_pkg::vec_op_e   op;
    vec_isa_pkg::vreg_idx_t vd;
    vec_isa_pkg::vreg_idx_t vs1;
    // Also the source for move and reduction
    vec_isa_pkg::vreg_idx_t vs2;
    vec_isa_pkg::elem_t     scalar;
  } lane_req_t;

  //////////////////////////////////////////////////
  // Per-lane completion

  // Partial sum and element 0 both come from vs2
  // and stay put until the next start
  typedef struct packed {
    logic               done;
    vec_isa_pkg::elem_t partial;
    vec_isa_pkg::elem_t elem0;
  } lane_res_t;

endpackage : vec_lane_pkg

`default_nettype wire

/* vec_dispatcher.sv */
//////////////////////////////////////////////////
// Host req/ack handshake, decode, scalar response
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Host side
  input  vec_isa_pkg::vec_insn_u  insn_i,
  input  logic                    req_i,
  output logic                    ack_o,
  output vec_isa_pkg::elem_t      resp_o,
  // Sequencer side
  output vec_lane_pkg::lane_req_t issue_o,
  output logic                    issue_valid_o,
  input  logic                    issue_done_i,
  // Scalar sources
  input  vec_isa_pkg::elem_t      elem0_i,
  input  vec_isa_pkg::elem_t      sum_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_ACK
  } state_e;

  state_e                  state_q;
  vec_lane_pkg::lane_req_t dec;
  vec_lane_pkg::lane_req_t issue_q;
  vec_isa_pkg::elem_t      resp_q;

  //////////////////////////////////////////////////
  // Decode

  // Opcode picks which view of the union is live
  always_comb begin
    dec    = '0;
    dec.op = insn_i.vv.opcode;
    dec.vd = insn_i.vv.vd;
    case (insn_i.vv.opcode)
      vec_isa_pkg::OP_VSPLAT: dec.scalar = insn_i.vx.scalar;
      default: begin
        dec.vs1 = insn_i.vv.vs1;
        dec.vs2 = insn_i.vv.vs2;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Handshake FSM

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:  if (req_i) state_q <= ST_ISSUE;
        ST_ISSUE: state_q <= ST_WAIT;
        ST_WAIT:  if (issue_done_i) state_q <= ST_ACK;
        // Hold ack until the host lets go
        ST_ACK:   if (!req_i) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      issue_q <= dec;
    end
    if (state_q == ST_WAIT && issue_done_i) begin
      case (issue_q.op)
        vec_isa_pkg::OP_VMV_XS:  resp_q <= elem0_i;
        vec_isa_pkg::OP_VREDSUM: resp_q <= sum_i;
        default:                 resp_q <= '0;
      endcase
    end
  end

  assign issue_o       = issue_q;
  assign issue_valid_o = (state_q == ST_ISSUE);
  assign ack_o         = (state_q == ST_ACK);
  assign resp_o        = resp_q;

  // Ack only ever answers a live request
  assert property (@(posedge clk_i) disable iff (reset_i) $rose(ack_o) |-> $past(req_i))
    else $error("ack_o rose while req_i was low");

endmodule : vec_dispatcher

`default_nettype wire

/* vec_sequencer.sv */
//////////////////////////////////////////////////
// Lane broadcast and completion collection
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_unit_cfg.svh"

module vec_sequencer (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  // Dispatcher side
  input  vec_lane_pkg::lane_req_t                      issue_i,
  input  logic                                         issue_valid_i,
  output logic                                         issue_done_o,
  // Lanes
  output vec_lane_pkg::lane_req_t                      lane_req_o,
  output logic                                         start_o,
  input  vec_lane_pkg::lane_res_t [`VEC_NR_LANES-1:0] lane_res_i,
  // Reducer
  output logic                                         reduce_start_o,
  input  logic                                         sum_valid_i
);

  localparam int unsigned NR_LANES = `VEC_NR_LANES;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_REDUCE
  } state_e;

  state_e                  state_q;
  vec_lane_pkg::lane_req_t req_q;
  logic                    start_q;
  logic [NR_LANES-1:0]     lane_done;
  logic [NR_LANES-1:0]     done_mask_q;
  logic [NR_LANES-1:0]     done_mask_d;
  logic                    all_done;
  logic                    is_red;

  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      lane_done[l] = lane_res_i[l].done;
    end
  end

  // Sticky mask, lanes may report in any cycle
  assign done_mask_d = done_mask_q | lane_done;
  assign all_done    = (state_q == ST_RUN) && (&done_mask_d);
  assign is_red      = (req_q.op == vec_isa_pkg::OP_VREDSUM);

  //////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_IDLE;
      start_q     <= 1'b0;
      done_mask_q <= '0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (issue_valid_i) begin
            start_q     <= 1'b1;
            done_mask_q <= '0;
            state_q     <= ST_RUN;
          end
        end
        ST_RUN: begin
          done_mask_q <= done_mask_d;
          if (&done_mask_d) state_q <= is_red ? ST_REDUCE : ST_IDLE;
        end
        ST_REDUCE: if (sum_valid_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Request stays on the bus for the whole run
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && issue_valid_i) req_q <= issue_i;
  end

  assign lane_req_o     = req_q;
  assign start_o        = start_q;
  assign reduce_start_o = all_done && is_red;
  assign issue_done_o   = (all_done && !is_red) || (state_q == ST_REDUCE && sum_valid_i);

  // Lanes only finish work that was started
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (state_q == ST_IDLE) |-> (lane_done == '0))
    else $error("lane done bit seen while sequencer idle");

endmodule : vec_sequencer

`default_nettype wire

/* vec_lane.sv */
//////////////////////////////////////////////////
// One lane: register file slice and integer ALU
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_unit_cfg.svh"

module vec_lane (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  vec_lane_pkg::lane_req_t lane_req_i,
  input  logic                    start_i,
  output vec_lane_pkg::lane_res_t lane_res_o
);

  localparam int unsigned NR_VREGS = `VEC_NR_VREGS;
  localparam int unsigned ELEMS    = `VEC_ELEMS_PER_LANE;
  localparam int unsigned CNT_W    = (ELEMS > 1) ? $clog2(ELEMS) : 1;

  // Slice of every register owned by this lane
  vec_isa_pkg::elem_t vrf_q [NR_VREGS][ELEMS];

  logic               busy_q;
  logic               done_q;
  logic [CNT_W-1:0]   cnt_q;
  logic               last;
  vec_isa_pkg::elem_t op_a;
  vec_isa_pkg::elem_t op_b;
  vec_isa_pkg::elem_t partial_q;
  vec_isa_pkg::elem_t elem0_q;

  assign op_a = vrf_q[lane_req_i.vs1][cnt_q];
  assign op_b = vrf_q[lane_req_i.vs2][cnt_q];
  assign last = (cnt_q == CNT_W'(ELEMS - 1));

  //////////////////////////////////////////////////
  // Element counter

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (last) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          cnt_q  <= '0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // ALU and write back, one element per cycle

  always_ff @(posedge clk_i) begin
    if (busy_q) begin
      case (lane_req_i.op)
        vec_isa_pkg::OP_VADD:   vrf_q[lane_req_i.vd][cnt_q] <= op_a + op_b;
        vec_isa_pkg::OP_VAND:   vrf_q[lane_req_i.vd][cnt_q] <= op_a & op_b;
        vec_isa_pkg::OP_VSPLAT: vrf_q[lane_req_i.vd][cnt_q] <= lane_req_i.scalar;
        default: ;
      endcase
    end
  end

  // Partial sum restarts on the first element
  always_ff @(posedge clk_i) begin
    if (busy_q) begin
      if (cnt_q == '0) begin
        partial_q <= op_b;
        elem0_q   <= op_b;
      end else begin
        partial_q <= partial_q + op_b;
      end
    end
  end

  assign lane_res_o.done    = done_q;
  assign lane_res_o.partial = partial_q;
  assign lane_res_o.elem0   = elem0_q;

  // Sequencer waits for every lane before restarting
  assert property (@(posedge clk_i) disable iff (reset_i) start_i |-> !busy_q)
    else $error("lane started while busy");

endmodule : vec_lane

`default_nettype wire

/* vec_reduce.sv */
//////////////////////////////////////////////////
// Two-stage adder tree over lane partial sums
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_unit_cfg.svh"

module vec_reduce (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  vec_isa_pkg::elem_t [`VEC_NR_LANES-1:0] partial_i,
  input  logic                                    reduce_start_i,
  output vec_isa_pkg::elem_t                      sum_o,
  output logic                                    sum_valid_o
);

  localparam int unsigned NR_LANES = `VEC_NR_LANES;
  localparam int unsigned NR_PAIRS = (NR_LANES > 1) ? NR_LANES / 2 : 1;

  vec_isa_pkg::elem_t [2*NR_PAIRS-1:0] padded;
  vec_isa_pkg::elem_t [NR_PAIRS-1:0]   pair_q;
  vec_isa_pkg::elem_t                  tree_sum;
  vec_isa_pkg::elem_t                  sum_q;
  logic                                stage1_valid_q;
  logic                                sum_valid_q;

  // Single lane gets a zero partner
  always_comb begin
    padded                 = '0;
    padded[NR_LANES-1:0]   = partial_i;
  end

  // Stage 1, pairwise sums
  always_ff @(posedge clk_i) begin
    if (reduce_start_i) begin
      for (int p = 0; p < NR_PAIRS; p++) begin
        pair_q[p] <= padded[2*p] + padded[2*p+1];
      end
    end
  end

  // Stage 2, fold the pairs, wraps at element width
  always_comb begin
    tree_sum = '0;
    for (int p = 0; p < NR_PAIRS; p++) begin
      tree_sum = tree_sum + pair_q[p];
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage1_valid_q) sum_q <= tree_sum;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage1_valid_q <= 1'b0;
      sum_valid_q    <= 1'b0;
    end else begin
      stage1_valid_q <= reduce_start_i;
      sum_valid_q    <= stage1_valid_q;
    end
  end

  assign sum_o       = sum_q;
  assign sum_valid_o = sum_valid_q;

endmodule : vec_reduce

`default_nettype wire

/* vec_unit.sv */
//////////////////////////////////////////////////
// Vector unit top: dispatcher, sequencer, lanes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_unit_cfg.svh"

module vec_unit (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  vec_isa_pkg::vec_insn_u insn_i,
  input  logic                   req_i,
  output logic                   ack_o,
  output vec_isa_pkg::elem_t     resp_o
);

  localparam int unsigned NR_LANES = `VEC_NR_LANES;

  // Dispatcher to sequencer
  vec_lane_pkg::lane_req_t                    issue;
  logic                                       issue_valid;
  logic                                       issue_done;
  // Sequencer to lanes and reducer
  vec_lane_pkg::lane_req_t                    lane_req;
  logic                                       start;
  logic                                       reduce_start;
  vec_lane_pkg::lane_res_t [NR_LANES-1:0]     lane_res;
  vec_isa_pkg::elem_t      [NR_LANES-1:0]     partials;
  vec_isa_pkg::elem_t                         sum;
  logic                                       sum_valid;

  vec_dispatcher i_dispatcher (
    .clk_i         (clk_i            ),
    .reset_i       (reset_i          ),
    .insn_i        (insn_i           ),
    .req_i         (req_i            ),
    .ack_o         (ack_o            ),
    .resp_o        (resp_o           ),
    .issue_o       (issue            ),
    .issue_valid_o (issue_valid      ),
    .issue_done_i  (issue_done       ),
    // Move reads element 0 from lane 0
    .elem0_i       (lane_res[0].elem0),
    .sum_i         (sum              )
  );

  vec_sequencer i_sequencer (
    .clk_i          (clk_i       ),
    .reset_i        (reset_i     ),
    .issue_i        (issue       ),
    .issue_valid_i  (issue_valid ),
    .issue_done_o   (issue_done  ),
    .lane_req_o     (lane_req    ),
    .start_o        (start       ),
    .lane_res_i     (lane_res    ),
    .reduce_start_o (reduce_start),
    .sum_valid_i    (sum_valid   )
  );

  //////////////////////////////////////////////////
  // Lanes

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i      (clk_i      ),
      .reset_i    (reset_i    ),
      .lane_req_i (lane_req   ),
      .start_i    (start      ),
      .lane_res_o (lane_res[l])
    );
    assign partials[l] = lane_res[l].partial;
  end : gen_lanes

  vec_reduce i_reduce (
    .clk_i          (clk_i       ),
    .reset_i        (reset_i     ),
    .partial_i      (partials    ),
    .reduce_start_i (reduce_start),
    .sum_o          (sum         ),
    .sum_valid_o    (sum_valid   )
  );

  if (NR_LANES < 1 || NR_LANES > 8 || NR_LANES != 2 ** $clog2(NR_LANES)) begin : gen_bad_lanes
    $error("vec_unit: lane count must be a power of two from 1 to 8");
  end

endmodule : vec_unit

`default_nettype wire

/* tb_clk_gen.sv */
//////////////////////////////////////////////////
// Testbench clock and reset source
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for 16 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule : tb_clk_gen

`default_nettype wire

/* tb_vec_unit.sv */
//////////////////////////////////////////////////
// Vector unit testbench: host driver, shadow model
// and response assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "vec_unit_cfg.svh"

module tb_vec_unit;

  localparam int unsigned NR_ELEMS  = `VEC_NR_LANES * `VEC_ELEMS_PER_LANE;
  localparam int unsigned NR_VREGS  = `VEC_NR_VREGS;
  localparam int unsigned WAIT_MAX  = 200;
  localparam int unsigned NR_ROUNDS = 12;

  logic                   clk;
  logic                   reset;
  vec_isa_pkg::vec_insn_u insn;
  logic                   req;
  logic                   ack;
  vec_isa_pkg::elem_t     resp;

  // Expected response of the instruction in flight
  vec_isa_pkg::elem_t exp_resp;
  string              test_name;
  int                 value_errs   = 0;
  int                 proto_errs   = 0;
  int                 timeout_errs = 0;
  bit                 timed_out    = 1'b0;

  // Every element of every register, all lanes
  vec_isa_pkg::elem_t shadow [NR_VREGS][NR_ELEMS];

  tb_clk_gen clk_gen_i (
    .clk_o   (clk  ),
    .reset_o (reset)
  );

  vec_unit dut_i (
    .clk_i   (clk  ),
    .reset_i (reset),
    .insn_i  (insn ),
    .req_i   (req  ),
    .ack_o   (ack  ),
    .resp_o  (resp )
  );

  //////////////////////////////////////////////////
  // Checks

  assert property (@(posedge clk) disable iff (reset) ack |-> (resp == exp_resp))
    else begin
      value_errs++;
      $display("ERR %s: expected %08h, actual %08h",
               test_name, $sampled(exp_resp), $sampled(resp));
    end

  // Req as seen on the edge where ack changed
  assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
    else begin
      proto_errs++;
      $display("Handshake error: ack_o rose while req_i was low");
    end

  // Ack drops one cycle after the unit sees req low
  assert property (@(posedge clk) disable iff (reset) (ack && !req) |=> !ack)
    else begin
      proto_errs++;
      $display("Handshake error: ack_o stayed high after req_i fell");
    end

  assert property (@(posedge clk) disable iff (reset) $fell(ack) |-> !$past(req))
    else begin
      proto_errs++;
      $display("Handshake error: ack_o fell while req_i was still high");
    end

  //////////////////////////////////////////////////
  // Instruction builders and model

  function automatic vec_isa_pkg::vec_insn_u make_vv(input vec_isa_pkg::vec_op_e op,
                                                      input int vd, input int vs1,
                                                      input int vs2);
    vec_isa_pkg::vec_insn_u w;
    w           = '0;
    w.vv.opcode = op;
    w.vv.vd     = vec_isa_pkg::vreg_idx_t'(vd);
    w.vv.vs1    = vec_isa_pkg::vreg_idx_t'(vs1);
    w.vv.vs2    = vec_isa_pkg::vreg_idx_t'(vs2);
    return w;
  endfunction

  function automatic vec_isa_pkg::vec_insn_u make_vx(input vec_isa_pkg::vec_op_e op,
                                                      input int vd,
                                                      input vec_isa_pkg::elem_t scalar);
    vec_isa_pkg::vec_insn_u w;
    w           = '0;
    w.vx.opcode = op;
    w.vx.vd     = vec_isa_pkg::vreg_idx_t'(vd);
    w.vx.scalar = scalar;
    return w;
  endfunction

  // Applies one instruction to the shadow registers, returns the response
  function automatic vec_isa_pkg::elem_t model_step(input vec_isa_pkg::vec_insn_u w);
    vec_isa_pkg::elem_t res;
    int                 vd;
    int                 vs1;
    int                 vs2;
    res = '0;
    vd  = int'(w.vv.vd);
    vs1 = int'(w.vv.vs1);
    vs2 = int'(w.vv.vs2);
    case (w.vv.opcode)
      vec_isa_pkg::OP_VADD:
        for (int e = 0; e < NR_ELEMS; e++) shadow[vd][e] = shadow[vs1][e] + shadow[vs2][e];
      vec_isa_pkg::OP_VAND:
        for (int e = 0; e < NR_ELEMS; e++) shadow[vd][e] = shadow[vs1][e] & shadow[vs2][e];
      vec_isa_pkg::OP_VSPLAT:
        for (int e = 0; e < NR_ELEMS; e++) shadow[vd][e] = w.vx.scalar;
      vec_isa_pkg::OP_VMV_XS:
        res = shadow[vs2][0];
      vec_isa_pkg::OP_VREDSUM:
        for (int e = 0; e < NR_ELEMS; e++) res = res + shadow[vs2][e];
      default: ;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Host side driver

  // Called 1 ns after a rising edge, returns at the same offset
  task automatic run_insn(input string name, input vec_isa_pkg::vec_insn_u w);
    int unsigned cycles;
    if (timed_out) return;
    test_name = name;
    exp_resp  = model_step(w);
    insn      = w;
    req       = 1'b1;
    cycles    = 0;
    while (ack !== 1'b1 && cycles < WAIT_MAX) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    req = 1'b0;
    if (ack !== 1'b1) begin
      timeout_errs++;
      timed_out = 1'b1;
      $display("Timeout: ack_o never rose for %s", name);
      return;
    end
    cycles = 0;
    while (ack !== 1'b0 && cycles < WAIT_MAX) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (ack !== 1'b0) begin
      timeout_errs++;
      timed_out = 1'b1;
      $display("Timeout: ack_o never fell after %s", name);
    end
  endtask

  task automatic run_round(input int r, input vec_isa_pkg::elem_t a,
                           input vec_isa_pkg::elem_t b);
    string tag;
    tag = $sformatf("round %0d", r);
    run_insn({tag, " splat v1"}, make_vx(vec_isa_pkg::OP_VSPLAT, 1, a));
    run_insn({tag, " splat v2"}, make_vx(vec_isa_pkg::OP_VSPLAT, 2, b));
    run_insn({tag, " move v1"}, make_vv(vec_isa_pkg::OP_VMV_XS, 0, 0, 1));
    run_insn({tag, " move v2"}, make_vv(vec_isa_pkg::OP_VMV_XS, 0, 0, 2));
    run_insn({tag, " add v3"}, make_vv(vec_isa_pkg::OP_VADD, 3, 1, 2));
    run_insn({tag, " move v3"}, make_vv(vec_isa_pkg::OP_VMV_XS, 0, 0, 3));
    run_insn({tag, " and v4"}, make_vv(vec_isa_pkg::OP_VAND, 4, 1, 2));
    run_insn({tag, " move v4"}, make_vv(vec_isa_pkg::OP_VMV_XS, 0, 0, 4));
    run_insn({tag, " redsum v3"}, make_vv(vec_isa_pkg::OP_VREDSUM, 0, 0, 3));
    run_insn({tag, " redsum v4"}, make_vv(vec_isa_pkg::OP_VREDSUM, 0, 0, 4));
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    int unsigned cycles;
    req       = 1'b0;
    insn      = '0;
    exp_resp  = '0;
    test_name = "reset";
    void'($urandom(71));

    cycles = 0;
    while (reset !== 1'b0 && cycles < WAIT_MAX) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (reset !== 1'b0) begin
      timeout_errs++;
      timed_out = 1'b1;
      $display("Timeout: reset_i never went low");
    end else begin
      assert (ack === 1'b0)
        else begin
          proto_errs++;
          $display("Handshake error: ack_o not low after reset");
        end
    end

    // Known contents in every register
    for (int r = 0; r < NR_VREGS; r++) begin
      run_insn($sformatf("init splat v%0d", r),
               make_vx(vec_isa_pkg::OP_VSPLAT, r, $urandom()));
    end

    // Sum wraps past 2^32
    run_round(0, 32'hFFFF_FFF0, 32'h0000_0025);
    for (int r = 1; r <= NR_ROUNDS; r++) begin
      run_round(r, $urandom(), $urandom());
    end

    @(posedge clk);
    #1;
    $display("Error counts: value %0d, handshake %0d, timeout %0d",
             value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_vec_unit

`default_nettype wire

/* vec_unit.f */
+incdir+.
vec_isa_pkg.sv
vec_lane_pkg.sv
vec_dispatcher.sv
vec_sequencer.sv
vec_lane.sv
vec_reduce.sv
vec_unit.sv
tb_clk_gen.sv
tb_vec_unit.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vec_unit -f vec_unit.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_vec_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
